/* unwrap_pkg.sv */
package unwrap_pkg;

  // --------------------
  // Default sizes
  // --------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned DataWidth = 32;
  // Upstream bursts that may wait for R beats at once
  localparam int unsigned MaxTxns   = 4;

  // --------------------
  // AXI field types
  // --------------------
  typedef logic [7:0] len_t;
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;

  localparam burst_t BurstFixed = 2'b00;
  localparam burst_t BurstIncr  = 2'b01;
  localparam burst_t BurstWrap  = 2'b10;

  // --------------------
  // Channel payloads
  // --------------------
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    len_t                 len;
    size_t                size;
    burst_t               burst;
  } ar_chan_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
    logic [1:0]           resp;
    logic                 last;
  } r_chan_t;

endpackage

/* len_fifo.sv */
`timescale 1ns/1ps

module len_fifo
  import unwrap_pkg::*;
#(
  parameter int unsigned MaxTxns = unwrap_pkg::MaxTxns
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic push_i,
  input  len_t push_len_i,
  input  logic pop_i,
  output len_t head_len_o,
  output logic not_empty_o,
  output logic not_full_o
);

  localparam int unsigned PtrWidth = (MaxTxns > 1) ? $clog2(MaxTxns) : 1;
  localparam int unsigned CntWidth = $clog2(MaxTxns + 1);

  typedef logic [PtrWidth-1:0] ptr_t;

  len_t                mem_q [MaxTxns];
  ptr_t                wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                do_push, do_pop;

  // Pointer increment that also handles depths other than a power of two
  function automatic ptr_t next_ptr(input ptr_t ptr);
    if (ptr == ptr_t'(MaxTxns - 1)) begin
      return '0;
    end
    return ptr + ptr_t'(1);
  endfunction

  assign not_empty_o = (count_q != '0);
  assign not_full_o  = (count_q != CntWidth'(MaxTxns));
  assign head_len_o  = mem_q[rd_ptr_q];

  assign do_push = push_i & not_full_o;
  assign do_pop  = pop_i & not_empty_o;

  // --------------------
  // Pointers and fill
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + CntWidth'(1);
        2'b01:   count_q <= count_q - CntWidth'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_len_i;
    end
  end

endmodule

/* ar_splitter.sv */
`timescale 1ns/1ps

module ar_splitter
  import unwrap_pkg::*;
#(
  parameter int unsigned AddrWidth = unwrap_pkg::AddrWidth
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  // Upstream AR
  input  ar_chan_t ar_i,
  input  logic     ar_valid_i,
  output logic     ar_ready_o,
  // Downstream AR
  output ar_chan_t ar_o,
  output logic     ar_valid_o,
  input  logic     ar_ready_i,
  // Length FIFO push side
  input  logic     fifo_not_full_i,
  output logic     push_o,
  output len_t     push_len_o
);

  typedef enum logic {
    Idle,
    Busy
  } state_e;

  state_e   state_d, state_q;
  ar_chan_t second_d, second_q;

  logic [AddrWidth-1:0] container_size;
  logic [AddrWidth-1:0] wrap_boundary;
  logic [AddrWidth-1:0] first_beats;
  logic [AddrWidth-1:0] second_beats;
  logic                 needs_split;
  logic                 idle_valid;

  // --------------------
  // Wrap geometry
  // --------------------
  // Total bytes covered by the burst, a power of two for legal WRAP bursts
  assign container_size = (AddrWidth'(ar_i.len) + AddrWidth'(1)) << ar_i.size;
  assign wrap_boundary  = ar_i.addr & ~(container_size - AddrWidth'(1));
  assign needs_split    = (ar_i.burst == BurstWrap) && (ar_i.addr != wrap_boundary);

  // Beats from start to top of container, and from boundary back up to start
  assign first_beats  = (wrap_boundary + container_size - ar_i.addr) >> ar_i.size;
  assign second_beats = (ar_i.addr - wrap_boundary) >> ar_i.size;

  // No new request may leave while the length FIFO has no room for it
  assign idle_valid = ar_valid_i & fifo_not_full_i;

  // --------------------
  // Request FSM
  // --------------------
  always_comb begin
    state_d    = state_q;
    second_d   = second_q;
    ar_o       = ar_i;
    ar_valid_o = 1'b0;
    ar_ready_o = 1'b0;

    case (state_q)
      Idle: begin
        if (ar_i.burst == BurstWrap) begin
          ar_o.burst = BurstIncr;
        end
        if (needs_split) begin
          ar_o.len = len_t'(first_beats - AddrWidth'(1));
        end
        ar_valid_o = idle_valid;
        ar_ready_o = ar_ready_i & fifo_not_full_i;

        // First half goes out now, keep the lower half for the next cycle
        if (idle_valid && ar_ready_i && needs_split) begin
          second_d       = ar_i;
          second_d.burst = BurstIncr;
          second_d.addr  = wrap_boundary;
          second_d.len   = len_t'(second_beats - AddrWidth'(1));
          state_d        = Busy;
        end
      end
      Busy: begin
        // Upstream is held off until the second INCR is taken
        ar_o       = second_q;
        ar_valid_o = 1'b1;
        if (ar_ready_i) begin
          state_d = Idle;
        end
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  // One FIFO entry per upstream request, holding its original length
  assign push_o     = ar_valid_i & ar_ready_o;
  assign push_len_o = ar_i.len;

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    second_q <= second_d;
  end

endmodule

/* r_last_gen.sv */
`timescale 1ns/1ps

module r_last_gen
  import unwrap_pkg::*;
(
  input  logic    clk_i,
  input  logic    arst_n_i,
  // Downstream R, its last flag marks split halves and is not used
  input  r_chan_t r_i,
  input  logic    r_valid_i,
  output logic    r_ready_o,
  // Upstream R
  output r_chan_t r_o,
  input  logic    r_ready_i,
  output logic    r_valid_o,
  // Length FIFO pop side
  input  len_t    head_len_i,
  input  logic    not_empty_i,
  output logic    pop_o
);

  len_t beat_cnt_q;
  logic beat_last;
  logic r_xfer;

  // Beats only flow once the burst they belong to is known
  assign r_valid_o = r_valid_i & not_empty_i;
  assign r_ready_o = r_ready_i & not_empty_i;
  assign r_xfer    = r_valid_i & r_ready_i & not_empty_i;

  assign beat_last = (beat_cnt_q == head_len_i);

  always_comb begin
    r_o      = r_i;
    r_o.last = beat_last;
  end

  // Final beat of the upstream burst retires its FIFO entry
  assign pop_o = r_xfer & beat_last;

  // --------------------
  // Beat counter
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beat_cnt_q <= '0;
    end else if (r_xfer) begin
      if (beat_last) begin
        beat_cnt_q <= '0;
      end else begin
        beat_cnt_q <= beat_cnt_q + len_t'(1);
      end
    end
  end

endmodule

/* burst_unwrap_top.sv */
`timescale 1ns/1ps

module burst_unwrap_top
  import unwrap_pkg::*;
#(
  parameter int unsigned AddrWidth = unwrap_pkg::AddrWidth,
  parameter int unsigned IdWidth   = unwrap_pkg::IdWidth,
  parameter int unsigned DataWidth = unwrap_pkg::DataWidth,
  parameter int unsigned MaxTxns   = unwrap_pkg::MaxTxns
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  // Upstream AR
  input  ar_chan_t ar_i,
  input  logic     ar_valid_i,
  output logic     ar_ready_o,
  // Downstream AR
  output ar_chan_t ar_o,
  output logic     ar_valid_o,
  input  logic     ar_ready_i,
  // Downstream R
  input  r_chan_t  r_i,
  input  logic     r_valid_i,
  output logic     r_ready_o,
  // Upstream R
  output r_chan_t  r_o,
  output logic     r_valid_o,
  input  logic     r_ready_i
);

  // Channel structs are built at the package widths
  if ((AddrWidth != unwrap_pkg::AddrWidth) || (IdWidth != unwrap_pkg::IdWidth) ||
      (DataWidth != unwrap_pkg::DataWidth)) begin : gen_width_check
    $fatal(1, "Width parameters differ from the unwrap_pkg channel structs");
  end

  logic fifo_not_full;
  logic fifo_not_empty;
  logic push;
  logic pop;
  len_t push_len;
  len_t head_len;

  ar_splitter #(
    .AddrWidth ( AddrWidth )
  ) i_ar_splitter (
    .clk_i           ( clk_i         ),
    .arst_n_i        ( arst_n_i      ),
    .ar_i            ( ar_i          ),
    .ar_valid_i      ( ar_valid_i    ),
    .ar_ready_o      ( ar_ready_o    ),
    .ar_o            ( ar_o          ),
    .ar_valid_o      ( ar_valid_o    ),
    .ar_ready_i      ( ar_ready_i    ),
    .fifo_not_full_i ( fifo_not_full ),
    .push_o          ( push          ),
    .push_len_o      ( push_len      )
  );

  len_fifo #(
    .MaxTxns ( MaxTxns )
  ) i_len_fifo (
    .clk_i       ( clk_i          ),
    .arst_n_i    ( arst_n_i       ),
    .push_i      ( push           ),
    .push_len_i  ( push_len       ),
    .pop_i       ( pop            ),
    .head_len_o  ( head_len       ),
    .not_empty_o ( fifo_not_empty ),
    .not_full_o  ( fifo_not_full  )
  );

  r_last_gen i_r_last_gen (
    .clk_i       ( clk_i          ),
    .arst_n_i    ( arst_n_i       ),
    .r_i         ( r_i            ),
    .r_valid_i   ( r_valid_i      ),
    .r_ready_o   ( r_ready_o      ),
    .r_o         ( r_o            ),
    .r_ready_i   ( r_ready_i      ),
    .r_valid_o   ( r_valid_o      ),
    .head_len_i  ( head_len       ),
    .not_empty_i ( fifo_not_empty ),
    .pop_o       ( pop            )
  );

endmodule

/* burst_unwrap_sva.sv */
`timescale 1ns/1ps

module burst_unwrap_sva
  import unwrap_pkg::*;
(
  input logic     clk_i,
  input logic     arst_n_i,
  input ar_chan_t ar_o,
  input logic     ar_valid_o,
  input logic     ar_ready_i,
  input r_chan_t  r_o,
  input logic     r_valid_o,
  input logic     r_ready_i,
  input logic     push_i,
  input logic     not_full_i
);

  // --------------------
  // Handshake stability
  // --------------------
  ar_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
    else $error("Downstream AR changed or dropped before it was accepted");

  r_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
    else $error("Upstream R changed or dropped before it was accepted");

  // Length FIFO
  no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push_i |-> not_full_i)
    else $error("Length FIFO pushed while full");

  valid_after_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> !ar_valid_o && !r_valid_o)
    else $error("Valid output high right after reset");

endmodule

bind burst_unwrap_top burst_unwrap_sva i_burst_unwrap_sva (
  .clk_i      ( clk_i         ),
  .arst_n_i   ( arst_n_i      ),
  .ar_o       ( ar_o          ),
  .ar_valid_o ( ar_valid_o    ),
  .ar_ready_i ( ar_ready_i    ),
  .r_o        ( r_o           ),
  .r_valid_o  ( r_valid_o     ),
  .r_ready_i  ( r_ready_i     ),
  .push_i     ( push          ),
  .not_full_i ( fifo_not_full )
);

/* tb_burst_unwrap.sv */
`timescale 1ns/1ps

module tb_burst_unwrap
  import unwrap_pkg::*;
;

  localparam int unsigned NumReq    = 150;
  localparam int unsigned MaxCycles = 40000;
  // Window with upstream R held off so the length FIFO fills
  localparam int unsigned HoldStart = 200;
  localparam int unsigned HoldEnd   = 260;

  logic     clk_i, arst_n_i;
  ar_chan_t ar_i, ar_o;
  logic     ar_valid_i, ar_ready_o, ar_valid_o, ar_ready_i;
  r_chan_t  r_i, r_o;
  logic     r_valid_i, r_ready_o, r_valid_o, r_ready_i;

  integer      seed = 54211;
  ar_chan_t    exp_ar_q[$];
  ar_chan_t    slave_ar_q[$];
  len_t        exp_len_q[$];
  int unsigned sent_cnt, cycle_cnt, slave_beat, up_beat;
  logic        ar_done, r_done, saw_full;

  burst_unwrap_top #(
    .AddrWidth ( AddrWidth ),
    .IdWidth   ( IdWidth   ),
    .DataWidth ( DataWidth ),
    .MaxTxns   ( MaxTxns   )
  ) i_dut (
    .clk_i      ( clk_i      ),
    .arst_n_i   ( arst_n_i   ),
    .ar_i       ( ar_i       ),
    .ar_valid_i ( ar_valid_i ),
    .ar_ready_o ( ar_ready_o ),
    .ar_o       ( ar_o       ),
    .ar_valid_o ( ar_valid_o ),
    .ar_ready_i ( ar_ready_i ),
    .r_i        ( r_i        ),
    .r_valid_i  ( r_valid_i  ),
    .r_ready_o  ( r_ready_o  ),
    .r_o        ( r_o        ),
    .r_valid_o  ( r_valid_o  ),
    .r_ready_i  ( r_ready_i  )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic compare(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("[ERROR] %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic ar_chan_t random_request();
    ar_chan_t    req;
    logic [31:0] rnd;
    rnd       = $random(seed);
    req.id    = rnd[IdWidth-1:0];
    req.size  = size_t'(rand_below(3));
    req.burst = burst_t'(rand_below(3));
    // WRAP lengths must be 2, 4, 8 or 16 beats
    if (req.burst == BurstWrap) begin
      req.len = len_t'((2 << rand_below(4)) - 1);
    end else begin
      req.len = len_t'(rand_below(16));
    end
    rnd      = $random(seed);
    req.addr = rnd & ~((32'd1 << req.size) - 32'd1);
    return req;
  endfunction

  // Reference model of the downstream AR sequence for one upstream request
  task automatic expect_downstream(input ar_chan_t req);
    ar_chan_t        first, second;
    longint unsigned beat, span, base;
    logic            split;
    first = req;
    split = 1'b0;
    if (req.burst == BurstWrap) begin
      beat        = 64'd1 << req.size;
      span        = (longint'(req.len) + 1) * beat;
      base        = req.addr - (req.addr % span);
      first.burst = BurstIncr;
      if (base != req.addr) begin
        split       = 1'b1;
        second      = first;
        first.len   = len_t'((base + span - req.addr) / beat - 1);
        second.addr = base;
        second.len  = len_t'((req.addr - base) / beat - 1);
      end
    end
    exp_ar_q.push_back(first);
    if (split) begin
      exp_ar_q.push_back(second);
    end
  endtask

  // --------------------
  // Stimulus and checks
  // --------------------
  task automatic drive_inputs();
    if (ar_done) begin
      ar_valid_i = 1'b0;
    end
    if (!ar_valid_i && sent_cnt < NumReq && rand_below(4) != 0) begin
      ar_i       = random_request();
      ar_valid_i = 1'b1;
    end
    ar_ready_i = (rand_below(4) != 0);

    // In-order slave that offers at most one beat per cycle
    if (r_done) begin
      r_valid_i = 1'b0;
    end
    if (!r_valid_i && slave_ar_q.size() > 0 && rand_below(3) != 0) begin
      r_i.id    = slave_ar_q[0].id;
      r_i.data  = $random(seed);
      r_i.resp  = 2'(rand_below(4));
      r_i.last  = (slave_beat == slave_ar_q[0].len);
      r_valid_i = 1'b1;
    end
    r_ready_i = (cycle_cnt < HoldStart || cycle_cnt >= HoldEnd) && (rand_below(4) != 0);
    ar_done   = 1'b0;
    r_done    = 1'b0;
  endtask

  task automatic sample_outputs();
    ar_chan_t exp_ar;
    r_chan_t  exp_r;
    logic     burst_pending;
    burst_pending = (exp_len_q.size() != 0);
    if (exp_len_q.size() == MaxTxns) begin
      saw_full = 1'b1;
      compare("ar_ready_o with FIFO full", 64'd0, 64'(ar_ready_o));
    end
    // R handshakes only pass while an upstream burst is outstanding
    compare("r_valid_o", 64'(r_valid_i && burst_pending), 64'(r_valid_o));
    compare("r_ready_o", 64'(r_ready_i && burst_pending), 64'(r_ready_o));

    if (r_valid_o && r_ready_i) begin
      if (exp_len_q.size() == 0) begin
        abort_run("Upstream R beat returned with no burst outstanding");
      end else begin
        exp_r      = r_i;
        exp_r.last = (up_beat == exp_len_q[0]);
        compare("upstream R beat", exp_r, r_o);
        if (exp_r.last) begin
          up_beat = 0;
          void'(exp_len_q.pop_front());
        end else begin
          up_beat++;
        end
      end
    end
    if (r_valid_i && r_ready_o) begin
      r_done = 1'b1;
      if (slave_beat == slave_ar_q[0].len) begin
        slave_beat = 0;
        void'(slave_ar_q.pop_front());
      end else begin
        slave_beat++;
      end
    end

    if (ar_valid_i && ar_ready_o) begin
      expect_downstream(ar_i);
      exp_len_q.push_back(ar_i.len);
      sent_cnt++;
      ar_done = 1'b1;
    end
    if (ar_valid_o && ar_ready_i) begin
      if (exp_ar_q.size() == 0) begin
        abort_run("Downstream AR issued with no upstream request behind it");
      end else begin
        exp_ar = exp_ar_q.pop_front();
        compare("downstream AR", exp_ar, ar_o);
        slave_ar_q.push_back(ar_o);
      end
    end
  endtask

  initial begin
    ar_i       = '0;
    ar_valid_i = 1'b0;
    ar_ready_i = 1'b0;
    r_i        = '0;
    r_valid_i  = 1'b0;
    r_ready_i  = 1'b0;
    sent_cnt   = 0;
    cycle_cnt  = 0;
    slave_beat = 0;
    up_beat    = 0;
    ar_done    = 1'b0;
    r_done     = 1'b0;
    saw_full   = 1'b0;
    arst_n_i   = 1'b0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    while (!(sent_cnt == NumReq && exp_len_q.size() == 0 && exp_ar_q.size() == 0 &&
             slave_ar_q.size() == 0)) begin
      if (cycle_cnt == MaxCycles) begin
        abort_run("Timeout: traffic did not drain within the cycle limit");
      end else begin
        @(negedge clk_i);
        drive_inputs();
        // Outputs are settled well before the next rising edge
        #10;
        sample_outputs();
        cycle_cnt++;
      end
    end

    if (!saw_full) begin
      abort_run("The length FIFO never filled up to MaxTxns entries");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

/* vlog.f */
unwrap_pkg.sv
len_fifo.sv
ar_splitter.sv
r_last_gen.sv
burst_unwrap_top.sv
burst_unwrap_sva.sv
tb_burst_unwrap.sv

/* Bender.yml */
package:
  name: burst_unwrap

sources:
  - unwrap_pkg.sv
  - len_fifo.sv
  - ar_splitter.sv
  - r_last_gen.sv
  - burst_unwrap_top.sv
  - target: test
    files:
      - burst_unwrap_sva.sv
      - tb_burst_unwrap.sv
